// File: project.f
source/cpuPkg.sv
source/fetchUnit.sv
source/controlUnit.sv
source/regFile.sv
source/execUnit.sv
source/dataMem.sv
source/singleCpu.sv
tests/singleCpu_asserts.sv
tests/singleCpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module singleCpuTb -f project.f -o singleCpuSim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/singleCpuSim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: source/controlUnit.sv
`default_nettype none

// Decode of the fetched word into register indices, immediate and controls
module controlUnit import cpuPkg::*; (
    input  logic [xlen-1:0] inst,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [xlen-1:0] imm,
    output aluOpT           aluOp,
    output logic            aluSrcImm,
    output logic            regWrite,
    output logic            memWrite,
    output logic            memToReg,
    output logic            isBranch
);

    opcodeT          opcode;
    logic [2:0]      funct3;
    logic            funct7b5;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30]; // sub versus add

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // Sign-extended immediates
    assign immI = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign immS = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    // Branch offset in bytes, bit 0 always clear
    assign immB = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        // Safe defaults give a no-op
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        isBranch  = 1'b0;
        imm       = '0;

        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = funct7b5 ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  regWrite = 1'b0; // Shifts and sltu left out
                endcase
            end
            opImm: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                regWrite  = (funct3 == f3AddSub); // addi only
            end
            opLoad: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
                regWrite  = (funct3 == f3Word);
            end
            opStore: begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = (funct3 == f3Word);
            end
            opBranch: begin
                imm      = immB;
                aluOp    = aluSub; // Equal when difference is zero
                isBranch = (funct3 == f3Beq);
            end
            default: begin
                // Unknown opcode, nothing is written and nothing branches
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Data and address word width
    localparam int xlen = 32;

    // Major opcodes the core understands, everything else runs as a no-op
    typedef enum logic [6:0] {
        opReg    = 7'b0110011, // add sub and or xor slt
        opImm    = 7'b0010011, // addi only
        opLoad   = 7'b0000011, // lw only
        opStore  = 7'b0100011, // sw only
        opBranch = 7'b1100011  // beq only
    } opcodeT;

    // funct3 values of the supported forms
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010; // lw and sw
    localparam logic [2:0] f3Beq    = 3'b000;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt // Signed compare, result 0 or 1
    } aluOpT;

endpackage

`default_nettype wire

// File: source/dataMem.sv
`default_nettype none

// Word memory, synchronous write and combinational read
module dataMem import cpuPkg::*; #(
    parameter int dataDepth = 64
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wrData,
    input  logic            wrEn,
    output logic [xlen-1:0] rdData
);

    localparam int idxW = $clog2(dataDepth);

    logic [xlen-1:0] mem [dataDepth];
    logic [idxW-1:0] wordIdx;

    // Byte offset dropped, upper bits wrap around the depth
    assign wordIdx = addr[idxW+1:2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < dataDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx]; // Store visible to the next lw

endmodule

`default_nettype wire

// File: source/execUnit.sv
`default_nettype none

// ALU, branch resolution, data memory access and write-back mux
module execUnit import cpuPkg::*; #(
    parameter int dataDepth = 64
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rd1,
    input  logic [xlen-1:0] rd2,
    input  logic [xlen-1:0] imm,
    input  aluOpT           aluOp,
    input  logic            aluSrcImm,
    input  logic            memWrite,
    input  logic            memToReg,
    input  logic            isBranch,
    output logic [xlen-1:0] wbData,
    output logic            branchTaken,
    output logic [xlen-1:0] branchTarget
);

    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] memRdData;
    logic            lessThan;

    assign opB      = aluSrcImm ? imm : rd2;
    assign lessThan = $signed(rd1) < $signed(opB);

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = rd1 + opB;
            aluSub:  aluResult = rd1 - opB;
            aluAnd:  aluResult = rd1 & opB;
            aluOr:   aluResult = rd1 | opB;
            aluXor:  aluResult = rd1 ^ opB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, lessThan};
            default: aluResult = '0;
        endcase
    end

    // beq is taken when rs1 - rs2 comes out zero
    assign branchTaken  = isBranch && (aluResult == '0);
    assign branchTarget = pc + imm; // imm already a byte offset

    // ALU result doubles as the byte address
    dataMem #(
        .dataDepth(dataDepth)
    ) u_dataMem (
        .CLK    (CLK),
        .RST    (RST),
        .addr   (aluResult),
        .wrData (rd2),
        .wrEn   (memWrite),
        .rdData (memRdData)
    );

    assign wbData = memToReg ? memRdData : aluResult;

endmodule

`default_nettype wire

// File: source/fetchUnit.sv
`default_nettype none

// Program counter plus the instruction store
// Store is written through the load port, independent of reset
module fetchUnit import cpuPkg::*; #(
    parameter int instDepth = 64
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            loadEn,
    input  logic [xlen-1:0] loadAddr,
    input  logic [xlen-1:0] loadInst,
    input  logic            branchTaken,
    input  logic [xlen-1:0] branchTarget,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] inst
);

    // Word index bits, depth taken as a power of two so the slice wraps
    localparam int idxW = $clog2(instDepth);

    logic [xlen-1:0] instMem [instDepth];
    logic [idxW-1:0] loadIdx;
    logic [idxW-1:0] fetchIdx;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcNext;

    assign loadIdx  = loadAddr[idxW+1:2];
    assign fetchIdx = pc[idxW+1:2];

    // Program load, also allowed while the core sits in reset
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            instMem[loadIdx] <= loadInst;
        end
    end

    assign inst = instMem[fetchIdx]; // Combinational fetch

    assign pcPlus4 = pc + xlen'(4);
    assign pcNext  = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pcNext; // One instruction per edge
        end
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

// 32 x xlen register file, x0 hardwired to zero
module regFile import cpuPkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wbData,
    input  logic            regWrite,
    input  logic [4:0]      dbgReg,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2,
    output logic [xlen-1:0] dbgData
);

    logic [xlen-1:0] regs [1:31]; // No storage behind x0

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != 5'd0)) begin
            regs[rd] <= wbData;
        end
    end

    // Plain combinational reads, a same-edge write shows up next cycle
    assign rd1     = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2     = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbgData = (dbgReg == 5'd0) ? '0 : regs[dbgReg]; // Debug port

endmodule

`default_nettype wire

// File: source/singleCpu.sv
`default_nettype none

// Single-cycle RV32I subset core, one instruction per clock
module singleCpu import cpuPkg::*; #(
    parameter int instDepth = 64,
    parameter int dataDepth = 64
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            loadEn,   // Program load strobe
    input  logic [xlen-1:0] loadAddr, // Byte address
    input  logic [xlen-1:0] loadInst,
    input  logic [4:0]      dbgReg,
    output logic [xlen-1:0] dbgData,
    output logic [xlen-1:0] instOut,
    output logic [xlen-1:0] pcOut
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    aluOpT           aluOp;
    logic            aluSrcImm;
    logic            regWrite;
    logic            memWrite;
    logic            memToReg;
    logic            isBranch;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] wbData;
    logic            branchTaken;
    logic [xlen-1:0] branchTarget;

    assign instOut = inst;
    assign pcOut   = pc;

    fetchUnit #(
        .instDepth(instDepth)
    ) u_fetchUnit (
        .CLK          (CLK),
        .RST          (RST),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadInst     (loadInst),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .inst         (inst)
    );

    // Decode and register read both work straight off the fetched word
    controlUnit u_controlUnit (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .memToReg  (memToReg),
        .isBranch  (isBranch)
    );

    regFile u_regFile (
        .CLK      (CLK),
        .RST      (RST),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wbData   (wbData),
        .regWrite (regWrite),
        .dbgReg   (dbgReg),
        .rd1      (rd1),
        .rd2      (rd2),
        .dbgData  (dbgData)
    );

    execUnit #(
        .dataDepth(dataDepth)
    ) u_execUnit (
        .CLK          (CLK),
        .RST          (RST),
        .pc           (pc),
        .rd1          (rd1),
        .rd2          (rd2),
        .imm          (imm),
        .aluOp        (aluOp),
        .aluSrcImm    (aluSrcImm),
        .memWrite     (memWrite),
        .memToReg     (memToReg),
        .isBranch     (isBranch),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

endmodule

`default_nettype wire

// File: tests/singleCpuTb.sv
`default_nettype none

module singleCpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        CLK;
    logic        RST;
    logic        loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadInst;
    logic [4:0]  dbgReg;
    logic [31:0] dbgData;
    logic [31:0] instOut;
    logic [31:0] pcOut;

    // Test table, one program per entry
    logic [31:0] progMem [16][8];
    int          progLen [16];
    int          runCycles [16];
    logic [4:0]  chkReg [16];
    logic [31:0] expVal [16];
    string       testName [16];
    int          numTests = 0;

    logic [31:0] lcgState = 32'd85543;
    int          cycleCount = 0;
    int          cycleLimit = 1000;
    int          passCount = 0;
    int          failCount = 0;

    // R-type forms in table order
    logic [2:0] rFunct3 [5] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100};
    logic       rSub [5] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    string      rName [5] = '{"add", "sub", "and", "or", "xor"};

    singleCpu #(
        .instDepth(64),
        .dataDepth(64)
    ) u_singleCpu (
        .CLK      (CLK),
        .RST      (RST),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadInst (loadInst),
        .dbgReg   (dbgReg),
        .dbgData  (dbgData),
        .instOut  (instOut),
        .pcOut    (pcOut)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [11:0] randomImm();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[27:16]; // Upper bits, low ones repeat too fast
    endfunction

    function automatic logic [31:0] signExtend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encR(input logic sub, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {1'b0, sub, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return encI(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    // beq rs1, rs2, byte offset
    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] rExpected(input int k, input logic [31:0] x,
                                              input logic [31:0] y);
        case (k)
            0:       return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            default: return x ^ y;
        endcase
    endfunction

    task automatic beginEntry(input string name);
        testName[numTests] = name;
        progLen[numTests] = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        progMem[numTests][progLen[numTests]] = word;
        progLen[numTests] += 1;
    endtask

    task automatic closeEntry(input logic [4:0] r, input logic [31:0] expected);
        emit(encB(13'd0, 5'd0, 5'd0)); // Park on beq x0, x0, 0
        runCycles[numTests] = progLen[numTests] + 2;
        chkReg[numTests] = r;
        expVal[numTests] = expected;
        numTests += 1;
    endtask

    task automatic buildTable();
        logic [11:0] a;
        logic [11:0] b;
        for (int k = 0; k < 5; k++) begin
            a = randomImm();
            b = randomImm();
            beginEntry(rName[k]);
            emit(addi(5'd1, 5'd0, a));
            emit(addi(5'd2, 5'd0, b));
            emit(encR(rSub[k], 5'd2, 5'd1, rFunct3[k], 5'd3));
            closeEntry(5'd3, rExpected(k, signExtend12(a), signExtend12(b)));
        end
        a = randomImm() | 12'h800; // Force negative
        beginEntry("addi negative");
        emit(addi(5'd5, 5'd0, a));
        closeEntry(5'd5, signExtend12(a));
        // x1 negative, x2 positive
        a = randomImm() | 12'h800;
        b = randomImm() & 12'h7FF;
        beginEntry("slt neg pos");
        emit(addi(5'd1, 5'd0, a));
        emit(addi(5'd2, 5'd0, b));
        emit(encR(1'b0, 5'd2, 5'd1, 3'b010, 5'd3));
        closeEntry(5'd3, 32'd1);
        beginEntry("slt pos neg");
        emit(addi(5'd1, 5'd0, a));
        emit(addi(5'd2, 5'd0, b));
        emit(encR(1'b0, 5'd1, 5'd2, 3'b010, 5'd3));
        closeEntry(5'd3, 32'd0);
        a = randomImm();
        b = randomImm() & 12'h7FC; // Word-aligned base
        beginEntry("sw lw");
        emit(addi(5'd1, 5'd0, a));
        emit(addi(5'd2, 5'd0, b));
        emit({7'd0, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011}); // sw x1, 4(x2)
        emit(encI(12'd4, 5'd2, 3'b010, 5'd4, 7'b0000011));  // lw x4, 4(x2)
        closeEntry(5'd4, signExtend12(a));
        a = randomImm();
        b = a ^ 12'h001;
        beginEntry("beq taken");
        emit(addi(5'd6, 5'd0, a));
        emit(encB(13'd8, 5'd0, 5'd0)); // Skips the overwrite
        emit(addi(5'd6, 5'd0, b));
        closeEntry(5'd6, signExtend12(a));
        beginEntry("beq not taken");
        emit(addi(5'd1, 5'd0, 12'd1));
        emit(addi(5'd6, 5'd0, a));
        emit(encB(13'd8, 5'd0, 5'd1));
        emit(addi(5'd6, 5'd0, b));
        closeEntry(5'd6, signExtend12(b));
        beginEntry("addi to x0");
        emit(addi(5'd0, 5'd0, a));
        closeEntry(5'd0, 32'd0);
        beginEntry("unknown opcode");
        emit(addi(5'd7, 5'd0, a));
        emit(encI(b, 5'd0, 3'b000, 5'd7, 7'b1111111)); // Would hit x7 if decoded
        closeEntry(5'd7, signExtend12(a));
    endtask

    task automatic runTest(input int t);
        logic failed;
        failed = 1'b0;
        RST = 1'b1;
        dbgReg = chkReg[t];
        for (int i = 0; i < progLen[t]; i++) begin
            loadEn = 1'b1;
            loadAddr = 32'(i * 4);
            loadInst = progMem[t][i];
            @(posedge CLK);
            #1;
        end
        loadEn = 1'b0;
        if ((pcOut !== 32'd0) || (instOut !== progMem[t][0])) begin
            $display("Mismatch at %0t: test %0d %s, in reset pcOut %h instOut %h",
                     $time, t, testName[t], pcOut, instOut);
            failed = 1'b1;
        end
        RST = 1'b0;
        repeat (runCycles[t]) @(posedge CLK);
        #1;
        if (dbgData !== expVal[t]) begin
            $display("Mismatch at %0t: test %0d %s, x%0d is %h, expected %h",
                     $time, t, testName[t], chkReg[t], dbgData, expVal[t]);
            failed = 1'b1;
        end
        if (failed) begin
            failCount++;
            $display("FAIL test %0d %s", t, testName[t]);
        end else begin
            passCount++;
            $display("PASS test %0d %s", t, testName[t]);
        end
    endtask

    initial begin
        CLK = 1'b0;
        RST = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadInst = '0;
        dbgReg = '0;
        buildTable();
        cycleLimit = 4 + 20; // Reset plus margin
        for (int t = 0; t < numTests; t++) begin
            cycleLimit += progLen[t] + runCycles[t] + 2;
        end
        repeat (4) @(posedge CLK);
        #1;
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/singleCpu_asserts.sv
`default_nettype none

// Properties checked inside the core top level
module singleCpu_asserts import cpuPkg::*; (
    input logic            CLK,
    input logic            RST,
    input logic [xlen-1:0] pc,
    input logic            branchTaken,
    input logic [4:0]      dbgReg,
    input logic [xlen-1:0] dbgData,
    input logic [xlen-1:0] memRdData
);
    timeunit 1ns;
    timeprecision 1ps;

    // A reset edge leaves registers and data memory all zero
    resetQuiet: assert property (@(posedge CLK) RST |=> (dbgData == '0) && (memRdData == '0))
        else $error("register or data memory written while reset was held");

    pcStep: assert property (@(posedge CLK) (!RST && !branchTaken) |=> (pc == $past(pc) + 32'd4))
        else $error("pc did not advance by 4 without a taken branch");

    zeroReg: assert property (@(posedge CLK) (dbgReg == 5'd0) |-> (dbgData == '0))
        else $error("register 0 read back nonzero");

endmodule

bind singleCpu singleCpu_asserts u_singleCpu_asserts (
    .CLK         (CLK),
    .RST         (RST),
    .pc          (pc),
    .branchTaken (branchTaken),
    .dbgReg      (dbgReg),
    .dbgData     (dbgData),
    .memRdData   (u_execUnit.memRdData)
);

`default_nettype wire
